/* tb.f */
hdl/decodePkg.sv
hdl/instDecoder.sv
hdl/regFile.sv
hdl/pairCombine.sv
hdl/decoderRfConv.sv
tb/decoderRfConv_checker.sv
tb/tbDecoderRfConv.sv

/* Makefile */
TOP := tbDecoderRfConv

all: run

build:
	verilator --binary --assert -f tb.f --top-module $(TOP) -Mdir obj_dir

# The log decides pass or fail
run: build
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -qx "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* tb/tbDecoderRfConv.sv */
`default_nettype none

module tbDecoderRfConv import decodePkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    logic    clk = 1'b0;
    logic    rst;
    instWord instA;
    instWord instB;
    logic    wrEnA;
    logic    wrEnB;
    regAddr  wrAddrA;
    regAddr  wrAddrB;
    regData  wrDataA;
    regData  wrDataB;
    logic    validA;
    logic    validB;
    logic    errorA;
    logic    errorB;
    opClass  opClassA;
    opClass  opClassB;
    aluOp    aluOpA;
    aluOp    aluOpB;
    regAddr  rdOutA;
    regAddr  rdOutB;
    regData  src1A;
    regData  src1B;
    regData  src2A;
    regData  src2B;
    logic    hazardB;

    int seed = 78;
    int timeouts = 0;

    decoderRfConv decoderRfConv_i (.*);

    bind decoderRfConv decoderRfConvChecker checkerInst (.*);

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////
    // Instruction builders
    //////////////////////////////

    function automatic instWord encodeR(input logic [6:0] f7, input int rs2, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] opc);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instWord encodeI(input logic [11:0] imm, input int rs1,
                                        input logic [2:0] f3, input int rd,
                                        input logic [6:0] opc);
        return {imm, rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic instWord encodeU(input logic [19:0] imm, input int rd,
                                        input logic [6:0] opc);
        return {imm, rd[4:0], opc};
    endfunction

    // Opcode for random words, decodable forms only
    function automatic logic [6:0] pickOpcode(input logic [1:0] sel);
        case (sel)
            2'd0:    return opcOp;
            2'd1:    return opcOpImm;
            2'd2:    return opcLui;
            default: return opcAuipc;
        endcase
    endfunction

    //////////////////////////////
    // Drive and wait
    //////////////////////////////

    task automatic driveCycle(input instWord a, input instWord b, input logic enA,
                              input int addrA, input regData dataA, input logic enB,
                              input int addrB, input regData dataB);
        @(posedge clk);
        instA   <= a;
        instB   <= b;
        wrEnA   <= enA;
        wrAddrA <= regAddr'(addrA);
        wrDataA <= dataA;
        wrEnB   <= enB;
        wrAddrB <= regAddr'(addrB);
        wrDataB <= dataB;
    endtask

    // Pair with no writeback
    task automatic issuePair(input instWord a, input instWord b);
        driveCycle(a, b, 1'b0, 0, '0, 1'b0, 0, '0);
    endtask

    task automatic waitIdle(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while ((validA || validB || errorA || errorB || hazardB) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (validA || validB || errorA || errorB || hazardB) begin
            timeouts++;
            $display("Timed out waiting for the outputs to go idle after reset");
        end
    endtask

    task automatic waitValidPair(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (!(validA && validB) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!(validA && validB)) begin
            timeouts++;
            $display("Timed out waiting for a valid pair on the outputs");
        end
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        instWord     nopWord;
        instWord     randA;
        instWord     randB;
        logic [31:0] rnd;
        int          checkErrs;

        nopWord = encodeI(12'h000, 0, 3'b000, 0, opcOpImm);
        rst     = 1'b1;
        instA   = nopWord;
        instB   = nopWord;
        wrEnA   = 1'b0;
        wrEnB   = 1'b0;
        wrAddrA = '0;
        wrAddrB = '0;
        wrDataA = '0;
        wrDataB = '0;

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        waitIdle(4);

        // Reads of the whole file before any write
        for (int r = 1; r < 32; r += 2) begin
            issuePair(encodeR(funct7Base, r + 1, r, 3'b000, 1, opcOp),
                      encodeR(funct7Base, 31 - r, 32 - r, 3'b000, 2, opcOp));
        end

        // Random contents, two registers per cycle
        for (int r = 1; r < 32; r += 2) begin
            driveCycle(nopWord, nopWord, 1'b1, r, $random(seed), r < 31, r + 1, $random(seed));
        end

        // OP and M groups over every funct3
        for (int f = 0; f < 8; f++) begin
            issuePair(encodeR(funct7Base, f + 1, f + 9, f[2:0], f + 17, opcOp),
                      encodeR(funct7Mul, 30 - f, f + 3, f[2:0], f + 20, opcOp));
        end
        issuePair(encodeR(funct7Alt, 2, 1, 3'b000, 5, opcOp),
                  encodeR(funct7Alt, 4, 3, 3'b101, 6, opcOp));

        // OP-IMM with shifts, negative and positive immediates
        issuePair(encodeI(12'h005, 8, 3'b001, 7, opcOpImm),
                  encodeI(12'hFFD, 10, 3'b000, 9, opcOpImm));
        issuePair(encodeI(12'h403, 11, 3'b101, 12, opcOpImm),
                  encodeI(12'h01F, 13, 3'b101, 14, opcOpImm));
        for (int f = 2; f < 8; f++) begin
            rnd = $random(seed);
            if (f != 5) begin
                issuePair(encodeI(rnd[11:0], f, f[2:0], f + 1, opcOpImm),
                          encodeI(rnd[23:12], f + 7, f[2:0], f + 8, opcOpImm));
            end
        end

        // Upper immediates
        issuePair(encodeU(20'hABCDE, 11, opcLui), encodeU(20'h80001, 12, opcAuipc));

        // Illegal slot next to a legal one
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 5, 7'b1111111),
                  encodeR(funct7Base, 4, 3, 3'b000, 6, opcOp));
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 5, opcOp),
                  encodeR(7'b0000010, 4, 3, 3'b000, 6, opcOp));
        issuePair(encodeI(12'h405, 1, 3'b001, 7, opcOpImm),
                  encodeI(12'h205, 2, 3'b101, 8, opcOpImm));
        issuePair(encodeR(funct7Alt, 2, 1, 3'b001, 9, opcOp),
                  encodeU(20'h12345, 10, opcLui));

        // Hazard on rs1, then on rs2
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 5, opcOp),
                  encodeR(funct7Base, 3, 5, 3'b000, 6, opcOp));
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 5, opcOp),
                  encodeR(funct7Alt, 5, 3, 3'b000, 6, opcOp));
        // x0 destination never hazards
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 0, opcOp),
                  encodeR(funct7Base, 0, 0, 3'b000, 3, opcOp));
        // Register fields that B does not use
        issuePair(encodeI(12'h001, 1, 3'b000, 7, opcOpImm),
                  encodeU(20'h00038, 8, opcLui));
        issuePair(encodeI(12'h001, 1, 3'b000, 7, opcOpImm),
                  encodeI(12'h007, 9, 3'b000, 8, opcOpImm));
        issuePair(encodeI(12'h001, 1, 3'b000, 7, opcOpImm),
                  encodeI(12'h403, 7, 3'b101, 8, opcOpImm));
        // Illegal A with rd field 5
        issuePair(encodeR(funct7Base, 2, 1, 3'b000, 5, 7'b0000000),
                  encodeR(funct7Base, 5, 5, 3'b000, 6, opcOp));

        // Both ports write x20 while both slots read it
        driveCycle(encodeR(funct7Base, 21, 20, 3'b000, 13, opcOp),
                   encodeR(funct7Base, 20, 22, 3'b000, 14, opcOp),
                   1'b1, 20, 32'h1111_1111, 1'b1, 20, 32'h2222_2222);
        // Port A alone on x21, port B on x22
        driveCycle(encodeR(funct7Base, 21, 20, 3'b000, 13, opcOp),
                   encodeR(funct7Base, 22, 21, 3'b000, 14, opcOp),
                   1'b1, 21, 32'h3333_3333, 1'b1, 22, 32'h4444_4444);
        // Stored values, nothing pending
        issuePair(encodeR(funct7Base, 21, 20, 3'b000, 13, opcOp),
                  encodeR(funct7Base, 20, 22, 3'b000, 14, opcOp));

        // Random words with a decodable opcode
        for (int n = 0; n < 24; n++) begin
            randA = $random(seed);
            randB = $random(seed);
            rnd   = $random(seed);
            randA[6:0] = pickOpcode(rnd[1:0]);
            randB[6:0] = pickOpcode(rnd[3:2]);
            if (rnd[4]) randA[31:25] = funct7Base;
            if (rnd[5]) randB[31:25] = funct7Mul;
            issuePair(randA, randB);
        end

        // Drain with legal pairs
        repeat (2) issuePair(nopWord, nopWord);
        waitValidPair(8);
        @(negedge clk);

        checkErrs = decoderRfConv_i.checkerInst.errCount;
        $display("Checker errors %0d, timeouts %0d", checkErrs, timeouts);
        if (checkErrs + timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/decoderRfConv_checker.sv */
`default_nettype none

module decoderRfConvChecker import decodePkg::*; (
    input logic    clk,
    input logic    rst,
    input instWord instA,
    input instWord instB,
    input logic    wrEnA,
    input logic    wrEnB,
    input regAddr  wrAddrA,
    input regAddr  wrAddrB,
    input regData  wrDataA,
    input regData  wrDataB,
    input logic    validA,
    input logic    validB,
    input logic    errorA,
    input logic    errorB,
    input opClass  opClassA,
    input opClass  opClassB,
    input aluOp    aluOpA,
    input aluOp    aluOpB,
    input regAddr  rdOutA,
    input regAddr  rdOutB,
    input regData  src1A,
    input regData  src1B,
    input regData  src2A,
    input regData  src2B,
    input logic    hazardB
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertion count for the closing line
    int errCount = 0;

    regData shadow [32];
    logic   seenEdge = 1'b0;
    logic   rstQ = 1'b1;
    logic   live;

    // Reference decode of the pair at the inputs
    logic   okA, u1A, u2A, uiA;
    logic   okB, u1B, u2B, uiB;
    opClass cA, cB;
    aluOp   oA, oB;
    regData immA, immB, s1A, s2A, s1B, s2B;
    logic   hazNow;

    // Prediction held for one cycle
    logic   pOkA, pOkB, pHaz;
    opClass pClsA, pClsB;
    aluOp   pOpA, pOpB;
    regAddr pRdA, pRdB;
    regData pS1A, pS2A, pS1B, pS2B;

    //////////////////////////////
    // Shadow register file
    //////////////////////////////

    // Port B written last so the younger write wins
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (wrEnA && wrAddrA != '0) shadow[wrAddrA] <= wrDataA;
            if (wrEnB && wrAddrB != '0) shadow[wrAddrB] <= wrDataB;
        end
    end

    // Value a read sees now with pending writes
    function automatic regData readNow(input regAddr a);
        if (a == '0) return '0;
        if (wrEnB && wrAddrB == a) return wrDataB;
        if (wrEnA && wrAddrA == a) return wrDataA;
        return shadow[a];
    endfunction

    //////////////////////////////
    // Reference decode
    //////////////////////////////

    // RV32IM encoding rules for the forms handled in decode
    function automatic void refDecode(input instWord i, output logic ok, output opClass c,
                                      output aluOp o, output logic useR1, output logic useR2,
                                      output logic useImm, output regData imm);
        logic [2:0] f3;
        logic [6:0] f7;
        f3     = i[14:12];
        f7     = i[31:25];
        ok     = 1'b1;
        c      = classNone;
        // Base and M codes follow funct3
        o      = aluOp'({1'b0, f3});
        useR1  = 1'b0;
        useR2  = 1'b0;
        useImm = 1'b0;
        imm    = '0;
        case (i[6:0])
            opcOp: begin
                useR1 = 1'b1;
                useR2 = 1'b1;
                c     = (f7 == funct7Mul) ? classMul : classAlu;
                if (f7 == funct7Alt) begin
                    // Only sub and sra
                    ok = (f3 == 3'b000) || (f3 == 3'b101);
                    o  = (f3 == 3'b000) ? aluSub : aluSra;
                end else begin
                    ok = (f7 == funct7Base) || (f7 == funct7Mul);
                end
            end
            opcOpImm: begin
                useR1  = 1'b1;
                useImm = 1'b1;
                c      = classAluImm;
                imm    = {{20{i[31]}}, i[31:20]};
                // Shift amounts need a clean upper field
                if (f3 == 3'b001) ok = (f7 == funct7Base);
                if (f3 == 3'b101) begin
                    ok = (f7 == funct7Base) || (f7 == funct7Alt);
                    if (f7 == funct7Alt) o = aluSra;
                end
            end
            opcLui, opcAuipc: begin
                useImm = 1'b1;
                imm    = {i[31:12], 12'b0};
                // U type has no funct3 field
                o      = aluAdd;
                c      = (i[6:0] == opcLui) ? classLui : classAuipc;
            end
            default: ok = 1'b0;
        endcase
        // Bubble
        if (!ok) begin
            c      = classNone;
            o      = aluAdd;
            useR1  = 1'b0;
            useR2  = 1'b0;
            useImm = 1'b0;
            imm    = '0;
        end
    endfunction

    always_comb begin
        refDecode(instA, okA, cA, oA, u1A, u2A, uiA, immA);
        refDecode(instB, okB, cB, oB, u1B, u2B, uiB, immB);
        s1A = u1A ? readNow(instA[19:15]) : '0;
        s1B = u1B ? readNow(instB[19:15]) : '0;
        s2A = uiA ? immA : (u2A ? readNow(instA[24:20]) : '0);
        s2B = uiB ? immB : (u2B ? readNow(instB[24:20]) : '0);
        // Every legal form writes rd
        hazNow = okA && instA[11:7] != '0 &&
                 ((u1B && instB[19:15] == instA[11:7]) || (u2B && instB[24:20] == instA[11:7]));
    end

    always @(posedge clk) begin
        seenEdge <= 1'b1;
        rstQ     <= rst;
        pOkA     <= okA;
        pOkB     <= okB;
        pClsA    <= cA;
        pClsB    <= cB;
        pOpA     <= oA;
        pOpB     <= oB;
        pRdA     <= okA ? instA[11:7] : '0;
        pRdB     <= okB ? instB[11:7] : '0;
        pS1A     <= s1A;
        pS1B     <= s1B;
        pS2A     <= s2A;
        pS2B     <= s2B;
        pHaz     <= hazNow;
    end

    // Outputs now belong to a pair taken out of reset
    assign live = seenEdge && !rstQ;

    //////////////////////////////
    // Assertions
    //////////////////////////////

    // Flags low right after a reset edge
    assert property (@(posedge clk) seenEdge && rstQ |->
                     !validA && !validB && !errorA && !errorB && !hazardB) else begin
        errCount++;
        $error("ERR %0t validA/validB/errorA/errorB/hazardB exp 00000 got %b%b%b%b%b", $time,
               $sampled(validA), $sampled(validB), $sampled(errorA), $sampled(errorB),
               $sampled(hazardB));
    end

    // Slot A
    assert property (@(posedge clk) live |-> {validA, errorA} === {pOkA, !pOkA}) else begin
        errCount++;
        $error("ERR %0t validA/errorA exp %b%b got %b%b", $time, $sampled(pOkA),
               !$sampled(pOkA), $sampled(validA), $sampled(errorA));
    end
    assert property (@(posedge clk) live |-> opClassA === pClsA) else begin
        errCount++;
        $error("ERR %0t opClassA exp %h got %h", $time, $sampled(pClsA), $sampled(opClassA));
    end
    assert property (@(posedge clk) live |-> aluOpA === pOpA) else begin
        errCount++;
        $error("ERR %0t aluOpA exp %h got %h", $time, $sampled(pOpA), $sampled(aluOpA));
    end
    assert property (@(posedge clk) live |-> rdOutA === pRdA) else begin
        errCount++;
        $error("ERR %0t rdOutA exp %h got %h", $time, $sampled(pRdA), $sampled(rdOutA));
    end
    assert property (@(posedge clk) live |-> src1A === pS1A) else begin
        errCount++;
        $error("ERR %0t src1A exp %h got %h", $time, $sampled(pS1A), $sampled(src1A));
    end
    assert property (@(posedge clk) live |-> src2A === pS2A) else begin
        errCount++;
        $error("ERR %0t src2A exp %h got %h", $time, $sampled(pS2A), $sampled(src2A));
    end

    // Slot B
    assert property (@(posedge clk) live |-> {validB, errorB} === {pOkB, !pOkB}) else begin
        errCount++;
        $error("ERR %0t validB/errorB exp %b%b got %b%b", $time, $sampled(pOkB),
               !$sampled(pOkB), $sampled(validB), $sampled(errorB));
    end
    assert property (@(posedge clk) live |-> opClassB === pClsB) else begin
        errCount++;
        $error("ERR %0t opClassB exp %h got %h", $time, $sampled(pClsB), $sampled(opClassB));
    end
    assert property (@(posedge clk) live |-> aluOpB === pOpB) else begin
        errCount++;
        $error("ERR %0t aluOpB exp %h got %h", $time, $sampled(pOpB), $sampled(aluOpB));
    end
    assert property (@(posedge clk) live |-> rdOutB === pRdB) else begin
        errCount++;
        $error("ERR %0t rdOutB exp %h got %h", $time, $sampled(pRdB), $sampled(rdOutB));
    end
    assert property (@(posedge clk) live |-> src1B === pS1B) else begin
        errCount++;
        $error("ERR %0t src1B exp %h got %h", $time, $sampled(pS1B), $sampled(src1B));
    end
    assert property (@(posedge clk) live |-> src2B === pS2B) else begin
        errCount++;
        $error("ERR %0t src2B exp %h got %h", $time, $sampled(pS2B), $sampled(src2B));
    end

    // Intra-pair RAW
    assert property (@(posedge clk) live |-> hazardB === pHaz) else begin
        errCount++;
        $error("ERR %0t hazardB exp %b got %b", $time, $sampled(pHaz), $sampled(hazardB));
    end

endmodule

`default_nettype wire

/* hdl/decoderRfConv.sv */
`default_nettype none

module decoderRfConv import decodePkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  instWord instA,
    input  instWord instB,
    // Writeback from later stages
    input  logic    wrEnA,
    input  logic    wrEnB,
    input  regAddr  wrAddrA,
    input  regAddr  wrAddrB,
    input  regData  wrDataA,
    input  regData  wrDataB,
    // To dispatch
    output logic    validA,
    output logic    validB,
    output logic    errorA,
    output logic    errorB,
    output opClass  opClassA,
    output opClass  opClassB,
    output aluOp    aluOpA,
    output aluOp    aluOpB,
    output regAddr  rdOutA,
    output regAddr  rdOutB,
    output regData  src1A,
    output regData  src1B,
    output regData  src2A,
    output regData  src2B,
    output logic    hazardB
);

    // Slot A decode
    regAddr rs1A, rs2A, rdA;
    opClass clsA;
    aluOp   opA;
    regData immA, rs1DataA, rs2DataA;
    logic   usesRs1A, usesRs2A, usesImmA, writesRdA, illegalA;

    // Slot B decode
    regAddr rs1B, rs2B, rdB;
    opClass clsB;
    aluOp   opB;
    regData immB, rs1DataB, rs2DataB;
    logic   usesRs1B, usesRs2B, usesImmB, writesRdB, illegalB;

    //////////////////////////////
    // Two decoders side by side
    //////////////////////////////

    instDecoder decodeA (
        .inst(instA), .rs1(rs1A), .rs2(rs2A), .rd(rdA), .cls(clsA), .op(opA),
        .imm(immA), .usesRs1(usesRs1A), .usesRs2(usesRs2A), .usesImm(usesImmA),
        .writesRd(writesRdA), .illegal(illegalA)
    );

    instDecoder decodeB (
        .inst(instB), .rs1(rs1B), .rs2(rs2B), .rd(rdB), .cls(clsB), .op(opB),
        .imm(immB), .usesRs1(usesRs1B), .usesRs2(usesRs2B), .usesImm(usesImmB),
        .writesRd(writesRdB), .illegal(illegalB)
    );

    // Ports 0 and 1 for A, 2 and 3 for B
    regFile regs (
        .clk(clk), .rst(rst),
        .wrEnA(wrEnA), .wrEnB(wrEnB), .wrAddrA(wrAddrA), .wrAddrB(wrAddrB),
        .wrDataA(wrDataA), .wrDataB(wrDataB),
        .rdAddr0(rs1A), .rdAddr1(rs2A), .rdAddr2(rs1B), .rdAddr3(rs2B),
        .rdData0(rs1DataA), .rdData1(rs2DataA), .rdData2(rs1DataB), .rdData3(rs2DataB)
    );

    pairCombine combine (
        .clk(clk), .rst(rst),
        .clsA(clsA), .opA(opA), .rdA(rdA), .immA(immA), .usesImmA(usesImmA),
        .writesRdA(writesRdA), .illegalA(illegalA), .rs1A(rs1A), .rs2A(rs2A),
        .usesRs1A(usesRs1A), .usesRs2A(usesRs2A),
        .rs1DataA(rs1DataA), .rs2DataA(rs2DataA),
        .clsB(clsB), .opB(opB), .rdB(rdB), .immB(immB), .usesImmB(usesImmB),
        .writesRdB(writesRdB), .illegalB(illegalB), .rs1B(rs1B), .rs2B(rs2B),
        .usesRs1B(usesRs1B), .usesRs2B(usesRs2B),
        .rs1DataB(rs1DataB), .rs2DataB(rs2DataB),
        .validA(validA), .validB(validB), .errorA(errorA), .errorB(errorB),
        .opClassA(opClassA), .opClassB(opClassB), .aluOpA(aluOpA), .aluOpB(aluOpB),
        .rdOutA(rdOutA), .rdOutB(rdOutB), .src1A(src1A), .src1B(src1B),
        .src2A(src2A), .src2B(src2B), .hazardB(hazardB)
    );

endmodule

`default_nettype wire

/* hdl/pairCombine.sv */
`default_nettype none

module pairCombine import decodePkg::*; (
    input  logic   clk,
    input  logic   rst,
    // Slot A, older
    input  opClass clsA,
    input  aluOp   opA,
    input  regAddr rdA,
    input  regData immA,
    input  logic   usesImmA,
    input  logic   writesRdA,
    input  logic   illegalA,
    input  regAddr rs1A,
    input  regAddr rs2A,
    input  logic   usesRs1A,
    input  logic   usesRs2A,
    input  regData rs1DataA,
    input  regData rs2DataA,
    // Slot B, younger
    input  opClass clsB,
    input  aluOp   opB,
    input  regAddr rdB,
    input  regData immB,
    input  logic   usesImmB,
    input  logic   writesRdB,
    input  logic   illegalB,
    input  regAddr rs1B,
    input  regAddr rs2B,
    input  logic   usesRs1B,
    input  logic   usesRs2B,
    input  regData rs1DataB,
    input  regData rs2DataB,
    // Decode/Dispatch register
    output logic   validA,
    output logic   validB,
    output logic   errorA,
    output logic   errorB,
    output opClass opClassA,
    output opClass opClassB,
    output aluOp   aluOpA,
    output aluOp   aluOpB,
    output regAddr rdOutA,
    output regAddr rdOutB,
    output regData src1A,
    output regData src1B,
    output regData src2A,
    output regData src2B,
    output logic   hazardB
);

    regData opnd1A;
    regData opnd1B;
    regData opnd2A;
    regData opnd2B;
    logic   rawB;

    // Register operand, zero when the field is unused or x0
    function automatic regData regOperand(input logic uses, input regAddr addr,
                                          input regData data);
        return (uses && addr != '0) ? data : '0;
    endfunction

    //////////////////////////////
    // Operand select
    //////////////////////////////

    // usesImm covers OP-IMM, LUI and AUIPC
    assign opnd1A = regOperand(usesRs1A, rs1A, rs1DataA);
    assign opnd1B = regOperand(usesRs1B, rs1B, rs1DataB);
    assign opnd2A = usesImmA ? immA : regOperand(usesRs2A, rs2A, rs2DataA);
    assign opnd2B = usesImmB ? immB : regOperand(usesRs2B, rs2B, rs2DataB);

    // Intra-pair RAW on A's destination
    assign rawB = !illegalA && writesRdA && rdA != '0 &&
                  ((usesRs1B && rs1B == rdA) || (usesRs2B && rs2B == rdA));

    //////////////////////////////
    // Output register
    //////////////////////////////

    // Control bits
    always_ff @(posedge clk) begin
        if (rst) begin
            validA  <= 1'b0;
            validB  <= 1'b0;
            errorA  <= 1'b0;
            errorB  <= 1'b0;
            hazardB <= 1'b0;
        end else begin
            validA  <= !illegalA;
            validB  <= !illegalB;
            errorA  <= illegalA;
            errorB  <= illegalB;
            hazardB <= rawB;
        end
    end

    // Payload, zeroed for a bubble
    always_ff @(posedge clk) begin
        opClassA <= illegalA ? classNone : clsA;
        aluOpA   <= illegalA ? aluAdd : opA;
        rdOutA   <= illegalA ? '0 : rdA;
        src1A    <= illegalA ? '0 : opnd1A;
        src2A    <= illegalA ? '0 : opnd2A;

        opClassB <= illegalB ? classNone : clsB;
        aluOpB   <= illegalB ? aluAdd : opB;
        rdOutB   <= illegalB ? '0 : rdB;
        src1B    <= illegalB ? '0 : opnd1B;
        src2B    <= illegalB ? '0 : opnd2B;
    end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`default_nettype none

module regFile import decodePkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   wrEnA,
    input  logic   wrEnB,
    input  regAddr wrAddrA,
    input  regAddr wrAddrB,
    input  regData wrDataA,
    input  regData wrDataB,
    input  regAddr rdAddr0,
    input  regAddr rdAddr1,
    input  regAddr rdAddr2,
    input  regAddr rdAddr3,
    output regData rdData0,
    output regData rdData1,
    output regData rdData2,
    output regData rdData3
);

    regData regs [32];

    //////////////////////////////
    // Write side
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wrEnA && wrAddrA != '0) regs[wrAddrA] <= wrDataA;
            // Later assignment wins, B is the younger instruction
            if (wrEnB && wrAddrB != '0) regs[wrAddrB] <= wrDataB;
        end
    end

    //////////////////////////////
    // Read side with bypass
    //////////////////////////////

    // Same priority as the write side
    function automatic regData readPort(input regAddr addr);
        regData val;
        if (addr == '0) val = '0;
        else if (wrEnB && wrAddrB == addr) val = wrDataB;
        else if (wrEnA && wrAddrA == addr) val = wrDataA;
        else val = regs[addr];
        return val;
    endfunction

    always_comb begin
        rdData0 = readPort(rdAddr0);
        rdData1 = readPort(rdAddr1);
        rdData2 = readPort(rdAddr2);
        rdData3 = readPort(rdAddr3);
    end

endmodule

`default_nettype wire

/* hdl/instDecoder.sv */
`default_nettype none

module instDecoder import decodePkg::*; (
    input  instWord inst,
    output regAddr  rs1,
    output regAddr  rs2,
    output regAddr  rd,
    output opClass  cls,
    output aluOp    op,
    output regData  imm,
    output logic    usesRs1,
    output logic    usesRs2,
    output logic    usesImm,
    output logic    writesRd,
    output logic    illegal
);

    //////////////////////////////
    // Field split
    //////////////////////////////

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regData     immI;
    regData     immU;
    logic       bad;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // Register fields go straight to the read ports
    assign rd  = inst[11:7];
    assign rs1 = inst[19:15];
    assign rs2 = inst[24:20];

    // I type, sign extended
    assign immI = {{20{inst[31]}}, inst[31:20]};
    // U type, low 12 bits clear
    assign immU = {inst[31:12], 12'b0};

    // Base op from funct3 plus the alternate bit
    function automatic aluOp baseOp(input logic [2:0] f3, input logic alt);
        aluOp res;
        case (f3)
            f3AddSub: res = alt ? aluSub : aluAdd;
            f3Sll:    res = aluSll;
            f3Slt:    res = aluSlt;
            f3Sltu:   res = aluSltu;
            f3Xor:    res = aluXor;
            f3SrlSra: res = alt ? aluSra : aluSrl;
            f3Or:     res = aluOr;
            f3And:    res = aluAnd;
            default:  res = aluAdd;
        endcase
        return res;
    endfunction

    //////////////////////////////
    // Class and op
    //////////////////////////////

    always_comb begin
        cls     = classNone;
        op      = aluAdd;
        imm     = '0;
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;
        usesImm = 1'b0;
        bad     = 1'b0;

        case (opcode)
            opcOp: begin
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (funct7)
                    funct7Base: begin
                        cls = classAlu;
                        op  = baseOp(funct3, 1'b0);
                    end
                    funct7Alt: begin
                        // Only sub and sra have an alternate form
                        if (funct3 == f3AddSub || funct3 == f3SrlSra) begin
                            cls = classAlu;
                            op  = baseOp(funct3, 1'b1);
                        end else begin
                            bad = 1'b1;
                        end
                    end
                    funct7Mul: begin
                        cls = classMul;
                        op  = aluOp'({1'b0, funct3});
                    end
                    default: bad = 1'b1;
                endcase
            end

            opcOpImm: begin
                cls     = classAluImm;
                usesRs1 = 1'b1;
                usesImm = 1'b1;
                imm     = immI;
                case (funct3)
                    // slli needs a clean upper field
                    f3Sll: begin
                        if (funct7 == funct7Base) op = aluSll;
                        else bad = 1'b1;
                    end
                    // srli / srai picked by bit 30
                    f3SrlSra: begin
                        if (funct7 == funct7Base) op = aluSrl;
                        else if (funct7 == funct7Alt) op = aluSra;
                        else bad = 1'b1;
                    end
                    // No subi, funct3 000 is always addi
                    default: op = baseOp(funct3, 1'b0);
                endcase
            end

            opcLui: begin
                cls     = classLui;
                usesImm = 1'b1;
                imm     = immU;
            end

            // PC is added later in the pipe
            opcAuipc: begin
                cls     = classAuipc;
                usesImm = 1'b1;
                imm     = immU;
            end

            default: bad = 1'b1;
        endcase

        // Illegal slot decodes as a bubble
        if (bad) begin
            cls     = classNone;
            op      = aluAdd;
            imm     = '0;
            usesRs1 = 1'b0;
            usesRs2 = 1'b0;
            usesImm = 1'b0;
        end
    end

    assign illegal  = bad;
    // Every legal form here has a destination
    assign writesRd = !bad;

endmodule

`default_nettype wire

/* hdl/decodePkg.sv */
`default_nettype none

package decodePkg;

    //////////////////////////////
    // Widths
    //////////////////////////////

    // One fetched instruction
    typedef logic [31:0] instWord;
    // Register index x0..x31
    typedef logic [4:0] regAddr;
    // Register value and immediate
    typedef logic [31:0] regData;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Major opcodes decoded in this stage
    localparam logic [6:0] opcOp    = 7'b0110011;
    localparam logic [6:0] opcOpImm = 7'b0010011;
    localparam logic [6:0] opcLui   = 7'b0110111;
    localparam logic [6:0] opcAuipc = 7'b0010111;

    // funct7 groups
    localparam logic [6:0] funct7Base = 7'b0000000;
    // sub / sra / srai
    localparam logic [6:0] funct7Alt  = 7'b0100000;
    // M extension
    localparam logic [6:0] funct7Mul  = 7'b0000001;

    // funct3 of the base integer ops
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    //////////////////////////////
    // Decoded types
    //////////////////////////////

    // Zero code is the bubble class
    typedef enum logic [2:0] {
        classAlu    = 3'd1,
        classAluImm = 3'd2,
        classLui    = 3'd3,
        classAuipc  = 3'd4,
        classMul    = 3'd5,
        classNone   = 3'd0
    } opClass;

    // Codes 0..7 follow funct3
    // Under classMul the same code reads as mul mulh mulhsu mulhu div divu rem remu
    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSll  = 4'd1,
        aluSlt  = 4'd2,
        aluSltu = 4'd3,
        aluXor  = 4'd4,
        aluSrl  = 4'd5,
        aluOr   = 4'd6,
        aluAnd  = 4'd7,
        aluSub  = 4'd8,
        aluSra  = 4'd9
    } aluOp;

endpackage

`default_nettype wire
